// ==== design/memtest_pkg.sv ====
// Shared widths, memory size, config register map and AXI channel types
// for the memory test subsystem. Modules pull these in with a wildcard
// import in their header.
package memtest_pkg;

   localparam int data_w          = 32;
   localparam int id_w            = 4;
   localparam int addr_w          = 32;
   localparam int mem_words       = 256;
   localparam int word_w          = $clog2(mem_words);  // word index, byte address bits [9:2]
   localparam int scrub_burst_len = 7;                  // beats per scrub burst minus one

   localparam logic [1:0] resp_okay = 2'b00;

   // config register byte offsets
   localparam logic [addr_w-1:0] cfg_ctrl   = 32'h00;
   localparam logic [addr_w-1:0] cfg_base   = 32'h04;
   localparam logic [addr_w-1:0] cfg_count  = 32'h08;
   localparam logic [addr_w-1:0] cfg_seed   = 32'h0C;
   localparam logic [addr_w-1:0] cfg_status = 32'h10;

   // port owner, also carried in the top two ID bits toward the memory
   typedef enum logic [1:0] {
      own_host  = 2'd0,
      own_gen   = 2'd1,
      own_scrub = 2'd2
   } owner_e;

   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [addr_w-1:0] addr;
      logic [7:0]        len;
   } axi_aw_t;

   typedef axi_aw_t axi_ar_t;

   typedef struct packed {
      logic [data_w-1:0]   data;
      logic [data_w/8-1:0] strb;
      logic                last;
   } axi_w_t;

   typedef struct packed {
      logic [id_w-1:0] id;
      logic [1:0]      resp;
   } axi_b_t;

   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [data_w-1:0] data;
      logic [1:0]        resp;
      logic              last;
   } axi_r_t;

endpackage

// ==== design/mem_scrubber.sv ====
// Memory scrubber. While scrub_enable is held it writes zero over the whole
// memory in fixed bursts, one burst at a time, and then holds scrub_done
// until enable drops. Dropping enable also rewinds it to address 0.
module mem_scrubber
   import memtest_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    scrub_enable,
   output axi_aw_t aw,
   output logic    aw_valid,
   input  logic    aw_ready,
   output axi_w_t  w,
   output logic    w_valid,
   input  logic    w_ready,
   input  axi_b_t  b,
   input  logic    b_valid,
   output logic    b_ready,
   output logic    scrub_done
);

   typedef enum logic [2:0] {s_idle, s_aw, s_w, s_b, s_done} state_e;

   state_e            state_q;
   logic [addr_w-1:0] addr_q;
   logic [7:0]        beat_q;
   logic              last_burst;

   assign last_burst = addr_q == addr_w'((mem_words - scrub_burst_len - 1) * 4);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= s_idle;
         addr_q  <= '0;
         beat_q  <= '0;
      end else begin
         unique case (state_q)
            s_idle: if (scrub_enable) state_q <= s_aw;
            s_aw: if (aw_ready) begin
               state_q <= s_w;
               beat_q  <= '0;
            end
            s_w: if (w_ready) begin
               beat_q <= beat_q + 8'd1;
               if (w.last) state_q <= s_b;
            end
            s_b: if (b_valid) begin
               if (b.resp != resp_okay) begin
                  state_q <= s_aw;  // error response, write the same burst again
               end else if (last_burst) begin
                  state_q <= s_done;
               end else begin
                  addr_q  <= scrub_enable ? addr_q + addr_w'((scrub_burst_len + 1) * 4) : '0;
                  state_q <= scrub_enable ? s_aw : s_idle;
               end
            end
            s_done: if (!scrub_enable) begin
               state_q <= s_idle;
               addr_q  <= '0;
            end
            default: state_q <= s_idle;
         endcase
      end
   end

   assign aw         = '{id: '0, addr: addr_q, len: 8'(scrub_burst_len)};
   assign w          = '{data: '0, strb: '1, last: beat_q == 8'(scrub_burst_len)};
   assign aw_valid   = state_q == s_aw;
   assign w_valid    = state_q == s_w;
   assign b_ready    = state_q == s_b;
   assign scrub_done = state_q == s_done;

endmodule

// ==== design/traffic_gen.sv ====
// Traffic generator. Config registers on the one-cycle-ack config bus, plus
// a pattern engine that writes address XOR seed over a range of words with
// single beats, reads the range back and counts mismatches. Writing bit 0 of
// the control register starts a run, and status bit 31 marks it done.
module traffic_gen
   import memtest_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic [addr_w-1:0] cfg_addr,
   input  logic [data_w-1:0] cfg_wdata,
   input  logic              cfg_wr,
   input  logic              cfg_rd,
   output logic              cfg_ack,
   output logic [data_w-1:0] cfg_rdata,
   output logic              gen_active,
   output axi_aw_t           aw,
   output logic              aw_valid,
   input  logic              aw_ready,
   output axi_w_t            w,
   output logic              w_valid,
   input  logic              w_ready,
   input  axi_b_t            b,
   input  logic              b_valid,
   output logic              b_ready,
   output axi_ar_t           ar,
   output logic              ar_valid,
   input  logic              ar_ready,
   input  axi_r_t            r,
   input  logic              r_valid,
   output logic              r_ready
);

   typedef enum logic [2:0] {g_idle, g_aw, g_w, g_b, g_ar, g_r} state_e;

   state_e            state_q;
   logic [addr_w-1:0] base_q;
   logic [data_w-1:0] count_q;
   logic [data_w-1:0] seed_q;
   logic [data_w-1:0] idx_q;
   logic [15:0]       mismatch_q;
   logic              done_q;
   logic [addr_w-1:0] cur_addr;
   logic [data_w-1:0] pattern;
   logic [data_w-1:0] status;
   logic              last_word;
   logic              start;

   assign start     = cfg_wr && cfg_addr == cfg_ctrl && cfg_wdata[0] && state_q == g_idle;
   assign cur_addr  = base_q + (idx_q << 2);
   assign pattern   = cur_addr ^ seed_q;
   assign last_word = idx_q == count_q - 1'b1;
   assign status    = {done_q, 15'b0, mismatch_q};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         base_q    <= '0;
         count_q   <= '0;
         seed_q    <= '0;
         cfg_ack   <= 1'b0;
         cfg_rdata <= '0;
      end else begin
         cfg_ack <= cfg_wr | cfg_rd;
         if (cfg_wr) begin
            case (cfg_addr)
               cfg_base:  base_q  <= cfg_wdata;
               cfg_count: count_q <= cfg_wdata;
               cfg_seed:  seed_q  <= cfg_wdata;
               default: ;
            endcase
         end
         if (cfg_rd) begin
            case (cfg_addr)
               cfg_ctrl:   cfg_rdata <= {31'b0, gen_active};
               cfg_base:   cfg_rdata <= base_q;
               cfg_count:  cfg_rdata <= count_q;
               cfg_seed:   cfg_rdata <= seed_q;
               cfg_status: cfg_rdata <= status;
               default:    cfg_rdata <= '0;
            endcase
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q    <= g_idle;
         idx_q      <= '0;
         mismatch_q <= '0;
         done_q     <= 1'b0;
      end else begin
         unique case (state_q)
            g_idle: if (start) begin
               idx_q      <= '0;
               mismatch_q <= '0;
               done_q     <= count_q == '0;  // empty range finishes at once
               if (count_q != '0) state_q <= g_aw;
            end
            g_aw: if (aw_ready) state_q <= g_w;
            g_w:  if (w_ready) state_q <= g_b;
            g_b: if (b_valid) begin
               if (b.resp != resp_okay) mismatch_q <= mismatch_q + 16'd1;
               idx_q   <= last_word ? '0 : idx_q + 1'b1;
               state_q <= last_word ? g_ar : g_aw;
            end
            g_ar: if (ar_ready) state_q <= g_r;
            g_r: if (r_valid) begin
               if (r.data != pattern || r.resp != resp_okay) mismatch_q <= mismatch_q + 16'd1;
               idx_q   <= idx_q + 1'b1;
               state_q <= last_word ? g_idle : g_ar;
               done_q  <= last_word;
            end
            default: state_q <= g_idle;
         endcase
      end
   end

   assign aw         = '{id: '0, addr: cur_addr, len: '0};
   assign ar         = '{id: '0, addr: cur_addr, len: '0};
   assign w          = '{data: pattern, strb: '1, last: 1'b1};
   assign aw_valid   = state_q == g_aw;
   assign w_valid    = state_q == g_w;
   assign b_ready    = state_q == g_b;
   assign ar_valid   = state_q == g_ar;
   assign r_ready    = state_q == g_r;
   assign gen_active = state_q != g_idle;

endmodule

// ==== design/test_port_mux.sv ====
// Port multiplexer for the memory. Picks one owner among scrubber, traffic
// generator and host by fixed priority, switching only when no burst is
// outstanding and the owner has nothing pending. Non-owners see ready and
// response valid low. The owner code rides in the top ID bits to the memory.
module test_port_mux
   import memtest_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    scrub_enable,
   input  logic    gen_active,
   input  axi_aw_t scrub_aw, gen_aw, host_aw,
   input  logic    scrub_aw_valid, gen_aw_valid, host_aw_valid,
   output logic    scrub_aw_ready, gen_aw_ready, host_aw_ready,
   input  axi_w_t  scrub_w, gen_w, host_w,
   input  logic    scrub_w_valid, gen_w_valid, host_w_valid,
   output logic    scrub_w_ready, gen_w_ready, host_w_ready,
   input  axi_ar_t scrub_ar, gen_ar, host_ar,
   input  logic    scrub_ar_valid, gen_ar_valid, host_ar_valid,
   output logic    scrub_ar_ready, gen_ar_ready, host_ar_ready,
   output axi_b_t  scrub_b, gen_b, host_b,
   output logic    scrub_b_valid, gen_b_valid, host_b_valid,
   input  logic    scrub_b_ready, gen_b_ready, host_b_ready,
   output axi_r_t  scrub_r, gen_r, host_r,
   output logic    scrub_r_valid, gen_r_valid, host_r_valid,
   input  logic    scrub_r_ready, gen_r_ready, host_r_ready,
   output axi_aw_t mem_aw,
   output logic    mem_aw_valid,
   input  logic    mem_aw_ready,
   output axi_w_t  mem_w,
   output logic    mem_w_valid,
   input  logic    mem_w_ready,
   output axi_ar_t mem_ar,
   output logic    mem_ar_valid,
   input  logic    mem_ar_ready,
   input  axi_b_t  mem_b,
   input  logic    mem_b_valid,
   output logic    mem_b_ready,
   input  axi_r_t  mem_r,
   input  logic    mem_r_valid,
   output logic    mem_r_ready
);

   owner_e          owner_q;
   owner_e          owner_want;
   logic [1:0]      count_q;  // outstanding bursts, the memory allows one
   logic [id_w-1:0] id_q;     // owner's own ID, handed back on responses
   logic [2:0]      grant;
   axi_aw_t         aw_m [3];
   axi_w_t          w_m [3];
   axi_ar_t         ar_m [3];
   logic [2:0]      aw_valid_m, w_valid_m, ar_valid_m, b_ready_m, r_ready_m;
   axi_aw_t         aw_sel;
   axi_ar_t         ar_sel;
   logic            aw_go, ar_go, b_go, r_go, b_own, r_own;

   // all master arrays are indexed by owner code
   assign aw_m       = '{host_aw, gen_aw, scrub_aw};
   assign w_m        = '{host_w, gen_w, scrub_w};
   assign ar_m       = '{host_ar, gen_ar, scrub_ar};
   assign aw_valid_m = {scrub_aw_valid, gen_aw_valid, host_aw_valid};
   assign w_valid_m  = {scrub_w_valid, gen_w_valid, host_w_valid};
   assign ar_valid_m = {scrub_ar_valid, gen_ar_valid, host_ar_valid};
   assign b_ready_m  = {scrub_b_ready, gen_b_ready, host_b_ready};
   assign r_ready_m  = {scrub_r_ready, gen_r_ready, host_r_ready};
   assign grant      = 3'b001 << owner_q;
   assign owner_want = scrub_enable ? own_scrub : gen_active ? own_gen : own_host;

   assign aw_sel       = aw_m[owner_q];
   assign ar_sel       = ar_m[owner_q];
   assign mem_aw       = '{id: {owner_q, aw_sel.id[id_w-3:0]}, addr: aw_sel.addr, len: aw_sel.len};
   assign mem_ar       = '{id: {owner_q, ar_sel.id[id_w-3:0]}, addr: ar_sel.addr, len: ar_sel.len};
   assign mem_w        = w_m[owner_q];
   assign mem_aw_valid = aw_valid_m[owner_q];
   assign mem_w_valid  = w_valid_m[owner_q];
   assign mem_ar_valid = ar_valid_m[owner_q];
   assign mem_b_ready  = b_ready_m[owner_q];
   assign mem_r_ready  = r_ready_m[owner_q];

   assign {scrub_aw_ready, gen_aw_ready, host_aw_ready} = grant & {3{mem_aw_ready}};
   assign {scrub_w_ready, gen_w_ready, host_w_ready}    = grant & {3{mem_w_ready}};
   assign {scrub_ar_ready, gen_ar_ready, host_ar_ready} = grant & {3{mem_ar_ready}};

   // a response only reaches the master whose tag it carries
   assign b_own = mem_b.id[id_w-1 -: 2] == owner_q;
   assign r_own = mem_r.id[id_w-1 -: 2] == owner_q;
   assign {scrub_b_valid, gen_b_valid, host_b_valid} = grant & {3{mem_b_valid & b_own}};
   assign {scrub_r_valid, gen_r_valid, host_r_valid} = grant & {3{mem_r_valid & r_own}};
   assign host_b  = '{id: id_q, resp: mem_b.resp};
   assign gen_b   = host_b;
   assign scrub_b = host_b;
   assign host_r  = '{id: id_q, data: mem_r.data, resp: mem_r.resp, last: mem_r.last};
   assign gen_r   = host_r;
   assign scrub_r = host_r;

   assign aw_go = mem_aw_valid & mem_aw_ready;
   assign ar_go = mem_ar_valid & mem_ar_ready;
   assign b_go  = mem_b_valid & mem_b_ready;
   assign r_go  = mem_r_valid & mem_r_ready & mem_r.last;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         owner_q <= own_host;
         count_q <= '0;
      end else begin
         count_q <= count_q + 2'(aw_go) + 2'(ar_go) - 2'(b_go) - 2'(r_go);
         if (count_q == '0 && !(mem_aw_valid | mem_w_valid | mem_ar_valid)) owner_q <= owner_want;
      end
   end

   always_ff @(posedge clk) begin
      if (aw_go) id_q <= aw_sel.id;
      else if (ar_go) id_q <= ar_sel.id;
   end

endmodule

// ==== design/axi_sram.sv ====
// Word memory behind an AXI slave port. Handles one burst at a time with
// incrementing addresses and byte strobes, echoes the ID and always answers
// OKAY. Byte addresses wrap modulo the memory size.
module axi_sram
   import memtest_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  axi_aw_t aw,
   input  logic    aw_valid,
   output logic    aw_ready,
   input  axi_w_t  w,
   input  logic    w_valid,
   output logic    w_ready,
   output axi_b_t  b,
   output logic    b_valid,
   input  logic    b_ready,
   input  axi_ar_t ar,
   input  logic    ar_valid,
   output logic    ar_ready,
   output axi_r_t  r,
   output logic    r_valid,
   input  logic    r_ready
);

   typedef enum logic [1:0] {m_idle, m_wr, m_resp, m_rd} state_e;

   state_e            state_q;
   logic [data_w-1:0] mem [mem_words];
   logic [word_w-1:0] word_q;
   logic [word_w-1:0] next_word;
   logic [id_w-1:0]   id_q;
   logic [7:0]        left_q;  // read beats still to go after the current one
   logic [data_w-1:0] rdata_q;

   assign aw_ready  = state_q == m_idle;
   assign ar_ready  = state_q == m_idle && !aw_valid;  // write wins a tie
   assign w_ready   = state_q == m_wr;
   assign b_valid   = state_q == m_resp;
   assign r_valid   = state_q == m_rd;
   assign b         = '{id: id_q, resp: resp_okay};
   assign r         = '{id: id_q, data: rdata_q, resp: resp_okay, last: left_q == '0};
   assign next_word = word_q + 1'b1;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= m_idle;
         left_q  <= '0;
      end else begin
         unique case (state_q)
            m_idle: begin
               if (aw_valid) begin
                  state_q <= m_wr;
               end else if (ar_valid) begin
                  state_q <= m_rd;
                  left_q  <= ar.len;
               end
            end
            m_wr:   if (w_valid && w.last) state_q <= m_resp;
            m_resp: if (b_ready) state_q <= m_idle;
            m_rd: if (r_ready) begin
               if (left_q == '0) state_q <= m_idle;
               else left_q <= left_q - 8'd1;
            end
            default: state_q <= m_idle;
         endcase
      end
   end

   // the first read word is fetched at ar acceptance, the next on each beat
   always_ff @(posedge clk) begin
      if (aw_valid && aw_ready) begin
         id_q   <= aw.id;
         word_q <= aw.addr[2 +: word_w];
      end else if (ar_valid && ar_ready) begin
         id_q    <= ar.id;
         word_q  <= ar.addr[2 +: word_w];
         rdata_q <= mem[ar.addr[2 +: word_w]];
      end
      if (w_valid && w_ready) begin
         for (int i = 0; i < data_w / 8; i++) begin
            if (w.strb[i]) mem[word_q][8*i +: 8] <= w.data[8*i +: 8];
         end
         word_q <= next_word;
      end
      if (r_valid && r_ready) begin
         word_q  <= next_word;
         rdata_q <= mem[next_word];
      end
   end

endmodule

// ==== design/memtest_top.sv ====
// Memory test subsystem top. The scrubber, the traffic generator and the
// external host port share one memory port through the priority mux.
module memtest_top
   import memtest_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              scrub_enable,
   output logic              scrub_done,
   input  logic [addr_w-1:0] cfg_addr,
   input  logic [data_w-1:0] cfg_wdata,
   input  logic              cfg_wr,
   input  logic              cfg_rd,
   output logic              cfg_ack,
   output logic [data_w-1:0] cfg_rdata,
   input  axi_aw_t           host_aw,
   input  logic              host_aw_valid,
   output logic              host_aw_ready,
   input  axi_w_t            host_w,
   input  logic              host_w_valid,
   output logic              host_w_ready,
   output axi_b_t            host_b,
   output logic              host_b_valid,
   input  logic              host_b_ready,
   input  axi_ar_t           host_ar,
   input  logic              host_ar_valid,
   output logic              host_ar_ready,
   output axi_r_t            host_r,
   output logic              host_r_valid,
   input  logic              host_r_ready
);

   logic    gen_active;
   axi_aw_t scrub_aw, gen_aw, mem_aw;
   axi_w_t  scrub_w, gen_w, mem_w;
   axi_ar_t scrub_ar, gen_ar, mem_ar;
   axi_b_t  scrub_b, gen_b, mem_b;
   axi_r_t  scrub_r, gen_r, mem_r;
   logic    scrub_aw_valid, scrub_aw_ready, scrub_w_valid, scrub_w_ready;
   logic    scrub_ar_valid, scrub_ar_ready, scrub_b_valid, scrub_b_ready;
   logic    scrub_r_valid, scrub_r_ready;
   logic    gen_aw_valid, gen_aw_ready, gen_w_valid, gen_w_ready;
   logic    gen_ar_valid, gen_ar_ready, gen_b_valid, gen_b_ready;
   logic    gen_r_valid, gen_r_ready;
   logic    mem_aw_valid, mem_aw_ready, mem_w_valid, mem_w_ready;
   logic    mem_ar_valid, mem_ar_ready, mem_b_valid, mem_b_ready;
   logic    mem_r_valid, mem_r_ready;

   // the scrubber only writes, so its read side stays idle
   assign scrub_ar       = '0;
   assign scrub_ar_valid = 1'b0;
   assign scrub_r_ready  = 1'b0;

   mem_scrubber i_mem_scrubber (
      .clk, .rst_n, .scrub_enable, .scrub_done,
      .aw(scrub_aw), .aw_valid(scrub_aw_valid), .aw_ready(scrub_aw_ready),
      .w(scrub_w), .w_valid(scrub_w_valid), .w_ready(scrub_w_ready),
      .b(scrub_b), .b_valid(scrub_b_valid), .b_ready(scrub_b_ready)
   );

   traffic_gen i_traffic_gen (
      .clk, .rst_n, .cfg_addr, .cfg_wdata, .cfg_wr, .cfg_rd, .cfg_ack, .cfg_rdata, .gen_active,
      .aw(gen_aw), .aw_valid(gen_aw_valid), .aw_ready(gen_aw_ready),
      .w(gen_w), .w_valid(gen_w_valid), .w_ready(gen_w_ready),
      .b(gen_b), .b_valid(gen_b_valid), .b_ready(gen_b_ready),
      .ar(gen_ar), .ar_valid(gen_ar_valid), .ar_ready(gen_ar_ready),
      .r(gen_r), .r_valid(gen_r_valid), .r_ready(gen_r_ready)
   );

   test_port_mux i_test_port_mux (.*);

   axi_sram i_axi_sram (
      .clk, .rst_n,
      .aw(mem_aw), .aw_valid(mem_aw_valid), .aw_ready(mem_aw_ready),
      .w(mem_w), .w_valid(mem_w_valid), .w_ready(mem_w_ready),
      .b(mem_b), .b_valid(mem_b_valid), .b_ready(mem_b_ready),
      .ar(mem_ar), .ar_valid(mem_ar_valid), .ar_ready(mem_ar_ready),
      .r(mem_r), .r_valid(mem_r_valid), .r_ready(mem_r_ready)
   );

endmodule

// ==== dv/tb_memtest.sv ====
// Testbench for the memory test subsystem. Reads one command per line from
// dv/memtest_testdata.txt and drives the host AXI port, the config bus and
// the scrub enable of the DUT, checking every response against the values
// given in the file. Run it from the project root.
module tb_memtest
   import memtest_pkg::*;
();

   logic              clk;
   logic              rst_n;
   logic              scrub_enable;
   logic              scrub_done;
   logic [addr_w-1:0] cfg_addr;
   logic [data_w-1:0] cfg_wdata;
   logic              cfg_wr;
   logic              cfg_rd;
   logic              cfg_ack;
   logic [data_w-1:0] cfg_rdata;
   axi_aw_t           host_aw;
   logic              host_aw_valid, host_aw_ready;
   axi_w_t            host_w;
   logic              host_w_valid, host_w_ready;
   axi_b_t            host_b;
   logic              host_b_valid, host_b_ready;
   axi_ar_t           host_ar;
   logic              host_ar_valid, host_ar_ready;
   axi_r_t            host_r;
   logic              host_r_valid, host_r_ready;

   int          cycles = 0;
   int          limit = 2000;  // raised once the data file is read
   logic [31:0] beat [4];      // write data or expected read data of the current command
   string       lines [$];

   memtest_top i_memtest_top (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      assert (cycles < limit) else begin
         $display("timeout after %0d cycles, the DUT stopped answering", cycles);
         abort_run();
      end
   end

   task automatic abort_run();
      $display(">>> FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         abort_run();
      end
   endtask

   // inputs change 10 units after the edge, outputs are sampled 1 unit later
   task automatic next_cycle();
      @(posedge clk);
      #10;
   endtask

   task automatic host_write(input logic [3:0] tid, input logic [31:0] taddr,
                             input logic [3:0] tstrb, input int len);
      host_aw       = '{id: tid, addr: taddr, len: 8'(len)};
      host_aw_valid = 1'b1;
      #1;
      while (!host_aw_ready) begin
         next_cycle();
         #1;
      end
      next_cycle();
      host_aw_valid = 1'b0;
      for (int i = 0; i <= len; i++) begin
         host_w       = '{data: beat[i], strb: tstrb, last: i == len};
         host_w_valid = 1'b1;
         #1;
         while (!host_w_ready) begin
            next_cycle();
            #1;
         end
         next_cycle();
      end
      host_w_valid = 1'b0;
      host_b_ready = 1'b1;
      #1;
      while (!host_b_valid) begin
         next_cycle();
         #1;
      end
      check_value("host_b.id", host_b.id, tid);
      check_value("host_b.resp", host_b.resp, resp_okay);
      next_cycle();
      host_b_ready = 1'b0;
   endtask

   task automatic host_read(input logic [3:0] tid, input logic [31:0] taddr, input int len);
      host_ar       = '{id: tid, addr: taddr, len: 8'(len)};
      host_ar_valid = 1'b1;
      #1;
      while (!host_ar_ready) begin  // held off while another master owns the port
         next_cycle();
         #1;
      end
      next_cycle();
      host_ar_valid = 1'b0;
      host_r_ready  = 1'b1;
      for (int i = 0; i <= len; i++) begin
         #1;
         while (!host_r_valid) begin
            next_cycle();
            #1;
         end
         check_value("host_r.data", host_r.data, beat[i]);
         check_value("host_r.id", host_r.id, tid);
         check_value("host_r.resp", host_r.resp, resp_okay);
         check_value("host_r.last", host_r.last, i == len);
         next_cycle();
      end
      host_r_ready = 1'b0;
   endtask

   task automatic cfg_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
      cfg_addr  = addr;
      cfg_wdata = wdata;
      cfg_wr    = wr;
      cfg_rd    = !wr;
      #1;
      check_value("cfg_ack", cfg_ack, 1'b0);  // no ack in the request cycle itself
      next_cycle();
      cfg_wr = 1'b0;
      cfg_rd = 1'b0;
      #1;
      check_value("cfg_ack", cfg_ack, 1'b1);
      rdata = cfg_rdata;
      next_cycle();
   endtask

   task automatic wait_gen_done();
      logic [31:0] status;
      status = '0;
      while (!status[31]) begin
         cfg_access(1'b0, cfg_status, '0, status);
      end
      check_value("cfg_rdata[15:0]", status[15:0], '0);  // mismatch count
   endtask

   task automatic scrub_run();
      check_value("scrub_done", scrub_done, 1'b0);
      scrub_enable = 1'b1;
      #1;
      while (!scrub_done) begin
         next_cycle();
         #1;
      end
      next_cycle();
      scrub_enable = 1'b0;
      next_cycle();
      #1;
      check_value("scrub_done", scrub_done, 1'b0);
   endtask

   // the generator takes the port one edge after its start is acked, before
   // the host read goes out, so the read can only finish after the run
   task automatic read_during_gen(input logic [3:0] tid, input logic [31:0] taddr);
      logic [31:0] status;
      cfg_access(1'b1, cfg_ctrl, 32'h1, status);
      host_read(tid, taddr, 0);
      cfg_access(1'b0, cfg_status, '0, status);
      check_value("cfg_rdata[31]", status[31], 1'b1);
   endtask

   initial begin
      int          fd;
      string       line;
      logic [7:0]  cmd;
      logic [31:0] f0, f1, f2, f3, f4, f5, f6, f7;
      logic [31:0] rdata;
      rst_n         = 1'b0;
      scrub_enable  = 1'b0;
      cfg_addr      = '0;
      cfg_wdata     = '0;
      cfg_wr        = 1'b0;
      cfg_rd        = 1'b0;
      host_aw       = '0;
      host_aw_valid = 1'b0;
      host_w        = '0;
      host_w_valid  = 1'b0;
      host_b_ready  = 1'b0;
      host_ar       = '0;
      host_ar_valid = 1'b0;
      host_r_ready  = 1'b0;

      fd = $fopen("dv/memtest_testdata.txt", "r");
      assert (fd != 0) else begin
         $display("could not open the test data file dv/memtest_testdata.txt");
         abort_run();
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line.getc(0) != "#") lines.push_back(line);
      end
      $fclose(fd);
      limit = 200 * lines.size() + 2000;

      repeat (4) @(posedge clk);
      #10;
      rst_n = 1'b1;
      next_cycle();

      foreach (lines[k]) begin
         void'($sscanf(lines[k], "%c %h %h %h %h %h %h %h %h",
                       cmd, f0, f1, f2, f3, f4, f5, f6, f7));
         case (cmd)
            "W": begin
               beat = '{f4, f5, f6, f7};
               host_write(f0[3:0], f1, f2[3:0], int'(f3));
            end
            "R": begin
               beat = '{f3, f4, f5, f6};
               host_read(f0[3:0], f1, int'(f2));
            end
            "C": cfg_access(1'b1, f0, f1, rdata);
            "Q": begin
               cfg_access(1'b0, f0, '0, rdata);
               check_value("cfg_rdata", rdata, f1);
            end
            "S": scrub_run();
            "G": wait_gen_done();
            "A": begin
               beat[0] = f2;
               read_during_gen(f0[3:0], f1);
            end
            default: begin
               assert (0) else begin
                  $display("unknown command in the test data: %s", lines[k]);
                  abort_run();
               end
            end
         endcase
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

// ==== dv/memtest_testdata.txt ====
# W id addr strb len d0 d1 d2 d3 | R id addr len e0 e1 e2 e3 | A id addr expected (read during run)
# C cfg_addr wdata | Q cfg_addr expected | S scrub run | G wait for generator done
W 1 00000100 f 0 12345678 0 0 0
R 2 00000100 0 12345678 0 0 0
W 3 00000100 3 0 aaaabbbb 0 0 0
R 4 00000100 0 1234bbbb 0 0 0
W 5 00000200 f 3 11111111 22222222 33333333 44444444
R 6 00000200 3 11111111 22222222 33333333 44444444
W 7 00000408 f 0 cafef00d 0 0 0
R 8 00000008 0 cafef00d 0 0 0
S
R 9 00000008 0 00000000 0 0 0
R a 00000200 3 00000000 00000000 00000000 00000000
R b 00000100 0 00000000 0 0 0
W c 0000003c f 0 0badcafe 0 0 0
W d 00000080 f 0 5555aaaa 0 0 0
C 04 00000040
C 08 00000010
C 0c a5a50000
Q 04 00000040
Q 08 00000010
Q 0c a5a50000
C 00 00000001
G
R e 00000040 3 a5a50040 a5a50044 a5a50048 a5a5004c
R f 0000007c 0 a5a5007c 0 0 0
R 1 0000003c 0 0badcafe 0 0 0
R 2 00000080 0 5555aaaa 0 0 0
A 3 00000044 a5a50044
R 4 00000078 0 a5a50078 0 0 0

// ==== verilog.f ====
design/memtest_pkg.sv
design/mem_scrubber.sv
design/traffic_gen.sv
design/test_port_mux.sv
design/axi_sram.sv
design/memtest_top.sv
dv/tb_memtest.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the memory test testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
   --top-module tb_memtest -Mdir obj_dir -o tb_memtest
./obj_dir/tb_memtest | tee sim.log

grep -qx ">>> PASS" sim.log
echo "simulation passed"
